// File: Makefile
# Verilator build and run for the core testbench

VERILATOR ?= verilator
TOP ?= coreTb
LOG ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with src.f, run into $(LOG) and check for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR, TOP, LOG, BUILD_DIR"

test:
	$(VERILATOR) --binary -Wno-fatal -f src.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/coreIfs.sv
src/instrFetch.sv
src/instrDecode.sv
src/regFile.sv
src/aluExecute.sv
src/coreTop.sv
test/coreTb.sv

// File: src/aluExecute.sv
// Operand select and ALU
`timescale 1ns/10ps

`include "core_params.svh"

module aluExecute import pipePkg::*; (
   input logic     bus,
   input logic     reset,
   issueIf.executor issue,
   regPortIf.user  port
);

   logic [`XLEN-1:0] result;
   logic [`XLEN-1:0] opA;
   logic [`XLEN-1:0] opB;

   // rm is both first operand and destination
   assign port.srcAddrA = issue.destReg;
   assign port.srcAddrB = issue.srcReg;
   assign opA = port.srcDataA;
   assign opB = port.srcDataB;

   always_comb begin
      case (issue.op)
         opAdd:   result = opA + opB;
         opSub:   result = opA - opB;
         opAnd:   result = opA & opB;
         opOr:    result = opA | opB;
         opXor:   result = opA ^ opB;
         default: result = {{(`XLEN - 32){issue.imm[31]}}, issue.imm};   // MOV imm32
      endcase
   end

   always_ff @(posedge bus) begin
      if (reset) begin
         port.wrEn <= 1'b0;
      end else begin
         port.wrEn <= issue.opValid;
      end
   end

   always_ff @(posedge bus) begin
      if (issue.opValid) begin
         port.wrAddr <= issue.destReg;
         port.wrData <= result;
      end
   end

endmodule

// File: src/coreIfs.sv
// Core internal interfaces
`timescale 1ns/10ps

`include "core_params.svh"

// Byte stream from fetch to decode
interface fetchIf import isaPkg::*; import pipePkg::*; ();
   instrWindowT window;     // Oldest buffer bytes
   byteCountT   byteCount;
   byteCountT   consume;    // Never above byteCount
   logic        halt;

   modport fetcher (output window, output byteCount, input consume, input halt);
   modport decoder (input window, input byteCount, output consume, output halt);
endinterface

// Registered decoder output
interface issueIf import pipePkg::*; ();
   logic        opValid;
   aluOpT       op;
   regIdxT      destReg;
   regIdxT      srcReg;
   logic [31:0] imm;

   modport issuer (output opValid, output op, output destReg, output srcReg, output imm);
   modport executor (input opValid, input op, input destReg, input srcReg, input imm);
   modport tracker (input opValid, input destReg);
endinterface

// Operand reads, write-back and scoreboard
interface regPortIf import pipePkg::*; ();
   regIdxT                srcAddrA;
   regIdxT                srcAddrB;
   logic [`XLEN-1:0]      srcDataA;
   logic [`XLEN-1:0]      srcDataB;
   logic                  wrEn;
   regIdxT                wrAddr;
   logic [`XLEN-1:0]      wrData;
   logic [`REG_COUNT-1:0] busy;

   modport user (
      output srcAddrA, output srcAddrB,
      input  srcDataA, input srcDataB,
      output wrEn, output wrAddr, output wrData
   );
   modport owner (
      input  srcAddrA, input srcAddrB,
      output srcDataA, output srcDataB,
      input  wrEn, input wrAddr, input wrData,
      output busy
   );
endinterface

// File: src/coreTop.sv
// Pipelined x86 subset core
`timescale 1ns/10ps

`include "core_params.svh"

module coreTop import pipePkg::*; (
   input  logic             bus,
   input  logic             reset,
   input  logic [`XLEN-1:0] entry,
   output logic             reqValid,
   output logic [`XLEN-1:0] reqAddr,
   input  logic             respValid,
   input  logic [`XLEN-1:0] respData,
   output logic             halted,
   input  regIdxT           dumpIndex,
   output logic [`XLEN-1:0] dumpValue
);

   fetchIf   fetchLink ();
   issueIf   issueLink ();
   regPortIf regLink ();

   instrFetch i_fetch (
      .bus       (bus),
      .reset     (reset),
      .entry     (entry),
      .reqValid  (reqValid),
      .reqAddr   (reqAddr),
      .respValid (respValid),
      .respData  (respData),
      .fetch     (fetchLink.fetcher)
   );

   instrDecode i_decode (
      .bus   (bus),
      .reset (reset),
      .fetch (fetchLink.decoder),
      .busy  (regLink.busy),
      .issue (issueLink.issuer)
   );

   aluExecute i_execute (
      .bus   (bus),
      .reset (reset),
      .issue (issueLink.executor),
      .port  (regLink.user)
   );

   regFile i_regFile (
      .bus       (bus),
      .reset     (reset),
      .port      (regLink.owner),
      .issue     (issueLink.tracker),
      .dumpIndex (dumpIndex),
      .dumpValue (dumpValue)
   );

   assign halted = fetchLink.halt;

endmodule

// File: src/core_params.svh
// Core widths and sizes
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Register and bus word width
`define XLEN 64

// Architectural registers
`define REG_COUNT 16

// Decoder window covers the longest instruction
`define WINDOW_BYTES 7

// Fetch byte buffer capacity
`define FETCH_BUF_BYTES 16

`endif

// File: src/instrDecode.sv
// Variable length decoder and issue
`timescale 1ns/10ps

`include "core_params.svh"

module instrDecode import isaPkg::*; import pipePkg::*; (
   input  logic                  bus,
   input  logic                  reset,
   fetchIf.decoder               fetch,
   input  logic [`REG_COUNT-1:0] busy,
   issueIf.issuer                issue
);

   localparam byteCountT ALU_LEN = 3;
   localparam byteCountT MOV_LEN = `WINDOW_BYTES;

   instrWindowT win;
   rexT         rex;
   opcodeT      opc;
   modRmT       modRm;
   logic        rexOk;
   logic        isAlu;
   logic        isMov;
   byteCountT   len;
   regIdxT      destReg;
   regIdxT      srcReg;
   logic        regBusy;
   logic        issueNow;
   logic        hltCand;
   logic        acceptHlt;
   aluOpT       aluOp;

   assign win = fetch.window;
   assign rex = win.aluForm.rex;
   assign opc = win.aluForm.opcode;
   assign modRm = win.aluForm.modRm;

   assign rexOk = (rex.fixed == 4'b0100) && rex.w;
   assign isAlu = rexOk && (modRm.mod == 2'b11)
                  && (opc inside {opcAdd, opcSub, opcAnd, opcOr, opcXor});
   assign isMov = rexOk && (modRm.mod == 2'b11) && (opc == opcMovImm) && (modRm.regOp == 3'd0);
   assign len = isMov ? MOV_LEN : ALU_LEN;

   assign destReg = {rex.b, modRm.rm};
   assign srcReg = {rex.r, modRm.regOp};

   // MOV reads no source
   assign regBusy = busy[destReg] || (isAlu && busy[srcReg]);
   assign issueNow = !fetch.halt && (isAlu || isMov) && (fetch.byteCount >= len) && !regBusy;

   // A REX head needs three bytes before it can be ruled out
   assign hltCand = !isAlu && !isMov
                    && (rexOk ? (fetch.byteCount >= ALU_LEN) : (fetch.byteCount != '0));
   assign acceptHlt = hltCand && (busy == '0) && !issue.opValid;

   assign fetch.consume = issueNow ? len : '0;

   always_comb begin
      case (opc)
         opcAdd:  aluOp = opAdd;
         opcSub:  aluOp = opSub;
         opcAnd:  aluOp = opAnd;
         opcOr:   aluOp = opOr;
         opcXor:  aluOp = opXor;
         default: aluOp = opMov;
      endcase
   end

   always_ff @(posedge bus) begin
      if (reset) begin
         issue.opValid <= 1'b0;
         fetch.halt <= 1'b0;
      end else begin
         issue.opValid <= issueNow;
         if (acceptHlt) fetch.halt <= 1'b1;   // Sticky until reset
      end
   end

   always_ff @(posedge bus) begin
      if (issueNow) begin
         issue.op <= aluOp;
         issue.destReg <= destReg;
         issue.srcReg <= srcReg;
         issue.imm <= win.immForm.imm32;
      end
   end

endmodule

// File: src/instrFetch.sv
// Instruction fetcher and byte buffer
`timescale 1ns/10ps

`include "core_params.svh"

module instrFetch import pipePkg::*; (
   input  logic             bus,
   input  logic             reset,
   input  logic [`XLEN-1:0] entry,
   output logic             reqValid,
   output logic [`XLEN-1:0] reqAddr,
   input  logic             respValid,
   input  logic [`XLEN-1:0] respData,
   fetchIf.fetcher          fetch
);

   localparam int BUF_BITS = 8 * `FETCH_BUF_BYTES;
   localparam int WORD_BYTES = `XLEN / 8;

   logic [BUF_BITS-1:0] bufFlat;   // Byte 0 is the oldest
   logic [BUF_BITS-1:0] bufNext;
   logic [BUF_BITS-1:0] keepMask;
   byteCountT           byteCount;
   byteCountT           remain;
   logic [`XLEN-1:0]    fetchAddr;
   logic                outstanding;
   logic                canReq;

   always_comb begin
      remain = byteCount - fetch.consume;
      keepMask = ~({BUF_BITS{1'b1}} << {remain, 3'b000});
      bufNext = (bufFlat >> {fetch.consume, 3'b000}) & keepMask;
      if (respValid) begin
         // Free space guarantees the word fits above remain
         bufNext = bufNext | ({{(BUF_BITS - `XLEN){1'b0}}, respData} << {remain, 3'b000});
      end
   end

   assign canReq = !outstanding && !fetch.halt
                   && (remain <= byteCountT'(`FETCH_BUF_BYTES - WORD_BYTES));

   always_ff @(posedge bus) begin
      if (reset) begin
         reqValid <= 1'b0;
         outstanding <= 1'b0;
         byteCount <= '0;
         fetchAddr <= entry;
      end else begin
         reqValid <= canReq;
         if (canReq) begin
            outstanding <= 1'b1;
            fetchAddr <= fetchAddr + `XLEN'(WORD_BYTES);
         end else if (respValid) begin
            outstanding <= 1'b0;
         end
         byteCount <= remain + (respValid ? byteCountT'(WORD_BYTES) : '0);
      end
   end

   always_ff @(posedge bus) begin
      bufFlat <= bufNext;
      if (canReq) reqAddr <= fetchAddr;
   end

   assign fetch.window = bufFlat[8*`WINDOW_BYTES-1:0];
   assign fetch.byteCount = byteCount;

endmodule

// File: src/isaPkg.sv
// x86 encoding types
package isaPkg;

   typedef enum logic [7:0] {
      opcAdd    = 8'h01,
      opcSub    = 8'h29,
      opcAnd    = 8'h21,
      opcOr     = 8'h09,
      opcXor    = 8'h31,
      opcMovImm = 8'hC7,
      opcHlt    = 8'hF4
   } opcodeT;

   typedef struct packed {
      logic [3:0] fixed;   // 4'b0100 for any REX
      logic       w;
      logic       r;       // Extends ModRM reg
      logic       x;
      logic       b;       // Extends ModRM rm
   } rexT;

   // ModRM with mod in the top two bits
   typedef struct packed {
      logic [1:0] mod;
      logic [2:0] regOp;
      logic [2:0] rm;
   } modRmT;

   // Byte 0 of the window sits in the low bits
   typedef union packed {
      struct packed {
         logic [31:0] unused;
         modRmT       modRm;
         opcodeT      opcode;
         rexT         rex;
      } aluForm;
      struct packed {
         logic [31:0] imm32;
         modRmT       modRm;
         opcodeT      opcode;
         rexT         rex;
      } immForm;
   } instrWindowT;

endpackage

// File: src/pipePkg.sv
// Pipeline internal types
package pipePkg;

`include "core_params.svh"

   typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

   // Bytes held in the fetch buffer from 0 to full
   typedef logic [$clog2(`FETCH_BUF_BYTES):0] byteCountT;

   typedef enum logic [2:0] {
      opAdd,
      opSub,
      opAnd,
      opOr,
      opXor,
      opMov
   } aluOpT;

endpackage

// File: src/regFile.sv
// Register file and scoreboard
`timescale 1ns/10ps

`include "core_params.svh"

module regFile import pipePkg::*; (
   input  logic             bus,
   input  logic             reset,
   regPortIf.owner          port,
   issueIf.tracker          issue,
   input  regIdxT           dumpIndex,
   output logic [`XLEN-1:0] dumpValue
);

   logic [`XLEN-1:0]      regs [`REG_COUNT];
   logic [`REG_COUNT-1:0] busyReg;
   logic [`REG_COUNT-1:0] issueMask;

   // Issued destination is busy already in its execute cycle
   assign issueMask = issue.opValid ? (`REG_COUNT'(1) << issue.destReg) : '0;
   assign port.busy = busyReg | issueMask;

   always_ff @(posedge bus) begin
      if (reset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
         busyReg <= '0;
      end else begin
         if (port.wrEn) begin
            regs[port.wrAddr] <= port.wrData;
            busyReg[port.wrAddr] <= 1'b0;
         end
         if (issue.opValid) busyReg[issue.destReg] <= 1'b1;
      end
   end

   assign port.srcDataA = regs[port.srcAddrA];
   assign port.srcDataB = regs[port.srcAddrB];
   assign dumpValue = regs[dumpIndex];

endmodule

// File: test/coreTb.sv
// Core testbench with random programs
`timescale 1ns/10ps

`include "core_params.svh"

module coreTb import isaPkg::*; import pipePkg::*; ();

   localparam int CLK_NS = 40;
   localparam int RESET_CYCLES = 8;
   localparam int PROG_LEN = 48;
   localparam int CHAIN_START = 8;
   localparam int CHAIN_LEN = 8;
   localparam logic [`XLEN-1:0] ENTRY = 64'h1000;
   // Four times the worst case of 8 cycles per instruction
   localparam int WATCHDOG_NS = 4 * PROG_LEN * 8 * CLK_NS;

   logic             bus;
   logic             reset;
   logic [`XLEN-1:0] entry;
   logic             reqValid;
   logic [`XLEN-1:0] reqAddr;
   logic             respValid;
   logic [`XLEN-1:0] respData;
   logic             halted;
   regIdxT           dumpIndex;
   logic [`XLEN-1:0] dumpValue;

   logic [31:0]      lfsrState;
   logic [7:0]       progBytes[$];   // Program image from ENTRY
   aluOpT            progOp [PROG_LEN];
   regIdxT           progDest [PROG_LEN];
   regIdxT           progSrc [PROG_LEN];
   logic [31:0]      progImm [PROG_LEN];
   logic [`XLEN-1:0] model [`REG_COUNT];
   logic [`XLEN-1:0] chainValue;
   regIdxT           chainReg;
   logic [`XLEN-1:0] expectAddr;
   logic             pending;
   logic             haltSeen;
   int               mismatchCount;
   int               failureCount;

   coreTop i_dut (
      .bus       (bus),
      .reset     (reset),
      .entry     (entry),
      .reqValid  (reqValid),
      .reqAddr   (reqAddr),
      .respValid (respValid),
      .respData  (respData),
      .halted    (halted),
      .dumpIndex (dumpIndex),
      .dumpValue (dumpValue)
   );

   initial begin
      bus = 1'b0;
      forever #(CLK_NS / 2) bus = ~bus;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   task automatic reportMismatch(input string name, input logic [`XLEN-1:0] expected,
                                 input logic [`XLEN-1:0] actual);
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      mismatchCount++;
   endtask

   task automatic reportFailure(input string what);
      $display("Failure at %0t ns: %s", $time, what);
      failureCount++;
   endtask

   task automatic encodeInstr(input int i);
      opcodeT opc;
      case (progOp[i])
         opAdd:   opc = opcAdd;
         opSub:   opc = opcSub;
         opAnd:   opc = opcAnd;
         opOr:    opc = opcOr;
         opXor:   opc = opcXor;
         default: opc = opcMovImm;
      endcase
      if (progOp[i] == opMov) begin
         progBytes.push_back({4'b0100, 3'b100, progDest[i][3]});   // REX.W B
         progBytes.push_back(opc);
         progBytes.push_back({2'b11, 3'b000, progDest[i][2:0]});
         for (int b = 0; b < 4; b++) begin
            progBytes.push_back(progImm[i][8*b +: 8]);   // Little endian
         end
      end else begin
         progBytes.push_back({4'b0100, 1'b1, progSrc[i][3], 1'b0, progDest[i][3]});
         progBytes.push_back(opc);
         progBytes.push_back({2'b11, progSrc[i][2:0], progDest[i][2:0]});
      end
   endtask

   task automatic genProgram();
      logic [2:0] pick;
      regIdxT     d;
      for (int i = 0; i < PROG_LEN; i++) begin
         if (i < CHAIN_START) begin
            progOp[i] = opMov;
            progDest[i] = regIdxT'(randBits(4));
         end else if (i < CHAIN_START + CHAIN_LEN) begin
            progOp[i] = opAdd;
            progDest[i] = progDest[i-1];   // Depends on the previous result
         end else begin
            pick = 3'(randBits(3));
            progOp[i] = (pick > 3'd4) ? opMov : aluOpT'(pick);
            d = regIdxT'(randBits(4));
            progDest[i] = (d == chainReg) ? (d ^ 4'h1) : d;   // Keep the chain result
         end
         progSrc[i] = regIdxT'(randBits(4));
         progImm[i] = randBits(32);
         if (i == CHAIN_START - 1) chainReg = progDest[i];
         encodeInstr(i);
      end
      progBytes.push_back(8'hF4);   // HLT
   endtask

   task automatic runModel();
      regIdxT d;
      regIdxT s;
      for (int r = 0; r < `REG_COUNT; r++) model[r] = '0;
      for (int i = 0; i < PROG_LEN; i++) begin
         d = progDest[i];
         s = progSrc[i];
         case (progOp[i])
            opAdd:   model[d] = model[d] + model[s];
            opSub:   model[d] = model[d] - model[s];
            opAnd:   model[d] = model[d] & model[s];
            opOr:    model[d] = model[d] | model[s];
            opXor:   model[d] = model[d] ^ model[s];
            default: model[d] = {{(`XLEN - 32){progImm[i][31]}}, progImm[i]};
         endcase
         if (i == CHAIN_START + CHAIN_LEN - 1) chainValue = model[d];
      end
   endtask

   // Bytes outside the image get a pattern of the full address
   function automatic logic [`XLEN-1:0] memWord(input logic [`XLEN-1:0] addr);
      logic [`XLEN-1:0] fill;
      logic [`XLEN-1:0] word;
      logic [`XLEN-1:0] offset;
      fill = addr ^ {addr[31:0], addr[63:32]} ^ 64'h5a5a_c3c3_0ff0_9669;
      for (int i = 0; i < 8; i++) begin
         offset = addr + i - ENTRY;
         if (addr + i >= ENTRY && offset < progBytes.size()) begin
            word[8*i +: 8] = progBytes[offset];
         end else begin
            word[8*i +: 8] = fill[8*i +: 8];
         end
      end
      return word;
   endfunction

   task automatic checkResetState(input string name);
      if (reqValid !== 1'b0) reportMismatch({name, " reqValid"}, '0, reqValid);
      if (halted !== 1'b0) reportMismatch({name, " halted"}, '0, halted);
      // Dump read is combinational
      for (int i = 0; i < `REG_COUNT; i++) begin
         dumpIndex = regIdxT'(i);
         #1;
         if (dumpValue !== '0) reportMismatch($sformatf("%s r%0d", name, i), '0, dumpValue);
      end
      dumpIndex = '0;
   endtask

   task automatic readReg(input regIdxT idx, output logic [`XLEN-1:0] value);
      @(posedge bus);
      #2 dumpIndex = idx;
      @(negedge bus);
      value = dumpValue;
   endtask

   // Memory model with 1 to 4 cycles of latency
   initial begin
      logic [`XLEN-1:0] addr;
      int               delay;
      forever begin
         @(negedge bus);
         if (!reset && reqValid) begin
            addr = reqAddr;
            delay = 1 + int'(randBits(2));
            repeat (delay) @(posedge bus);
            #2;
            respValid = 1'b1;
            respData = memWord(addr);
            @(posedge bus);
            #2 respValid = 1'b0;
         end
      end
   end

   // Bus and halt monitor
   initial begin
      pending = 1'b0;
      haltSeen = 1'b0;
      expectAddr = ENTRY;
      forever begin
         @(negedge bus);
         if (reset) begin
            if (reqValid !== 1'b0) reportMismatch("resetState reqValid", '0, reqValid);
            if (halted !== 1'b0) reportMismatch("resetState halted", '0, halted);
         end else begin
            if (haltSeen && reqValid) reportFailure("request issued after the core halted");
            if (haltSeen && !halted) reportFailure("halted dropped after it had risen");
            if (reqValid) begin
               if (pending) reportFailure("request issued while the previous one is unanswered");
               if (reqAddr !== expectAddr) reportMismatch("requestOrder", expectAddr, reqAddr);
               expectAddr = expectAddr + 8;
            end
            if (respValid) pending = 1'b0;
            if (reqValid) pending = 1'b1;
            if (halted) haltSeen = 1'b1;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns without the core halting", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      logic [`XLEN-1:0] value;
      reset = 1'b1;
      entry = ENTRY;
      respValid = 1'b0;
      respData = '0;
      dumpIndex = '0;
      lfsrState = 32'h8a34_dc19;
      mismatchCount = 0;
      failureCount = 0;
      genProgram();
      runModel();

      repeat (RESET_CYCLES - 1) @(posedge bus);
      #2 checkResetState("resetState");
      @(posedge bus);
      #2 reset = 1'b0;
      checkResetState("firstCycle");

      while (halted !== 1'b1) @(negedge bus);
      repeat (4) @(negedge bus);   // Halted must hold

      for (int i = 0; i < `REG_COUNT; i++) begin
         readReg(regIdxT'(i), value);
         if (value !== model[i]) reportMismatch($sformatf("archResult r%0d", i), model[i], value);
      end
      readReg(chainReg, value);
      if (value !== chainValue) reportMismatch("depChain", chainValue, value);

      $display("Done: %0d value errors, %0d other failures", mismatchCount, failureCount);
      if (mismatchCount == 0 && failureCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
